/* Bender.yml */
package:
  name: issue_unit

sources:
  - files:
      - design/issue_pkg.sv
      - design/busy_table.sv
      - design/rs_wakeup.sv
      - design/rs_select.sv
      - design/reservation_station.sv
      - design/issue_unit.sv
  - target: test
    files:
      - bench/tb_issue_unit.sv

/* bench/issue_cases.txt */
# c <req mode 0-3 fixed mask, 4 random> | d <cyc> <port> <op> <src0> <src1> <rd> <wen> <rob>
# w <cyc> <port> <tag> | r <cyc> <req mode> | k <cyc> <can_disp> <can_issue> | e <rob mask>
c 3
d 0 0 01 01 02 10 1 01
d 0 1 02 03 04 11 1 02
d 1 0 03 05 06 12 1 03
e e
c 3
d 0 0 10 01 02 21 1 05
d 0 1 11 03 04 22 1 08
d 1 0 12 21 05 23 1 06
d 3 0 13 06 22 24 1 07
w 3 2 22
d 6 0 14 07 08 21 1 09
w 6 0 21
d 7 0 15 21 09 25 0 0a
w a 1 21
e 7e0
c 0
d 0 0 20 01 02 00 0 10
d 0 1 21 01 02 00 0 11
d 1 0 22 03 04 00 0 12
d 1 1 23 03 04 00 0 13
d 2 0 24 05 06 00 0 14
d 2 1 25 05 06 00 0 15
d 3 0 26 07 08 00 0 16
d 3 1 27 07 08 00 0 17
k 4 0 3
k 5 0 3
r 6 1
k 7 1 3
r 8 3
e ff0000
c 4
d 0 0 40 01 02 38 1 28
d 0 1 41 03 04 39 1 29
d 1 0 42 38 39 3a 1 2a
d 1 1 30 05 06 30 1 20
d 2 0 43 3a 3a 3b 1 2b
d 2 1 31 07 08 31 1 21
w 4 0 38
w 5 1 39
w 9 3 3a
e f0300000000
c 3
d 0 0 50 01 02 3c 1 30
e 1000000000000
c 3
d 0 0 51 3c 3c 3d 1 31
e 2000000000000

/* bench/tb_issue_unit.sv */
`timescale 1ns/1ps

module tb_issue_unit
    import issue_pkg::*;
();

    localparam int PORT_NUM = 2;
    localparam int WB_NUM = 4;
    localparam int CASE_CYCLES = 200;

    // one cycle-stamped line of the case file
    typedef struct packed {
        logic [7:0]  kind;
        logic [7:0]  cidx;
        logic [15:0] cyc;
        logic [1:0]  port;
        disp_t       d;
        logic [7:0]  a;
        logic [7:0]  b;
    } event_t;

    logic                clk;
    logic                arst_n;
    logic [PORT_NUM-1:0] disp_vld;
    disp_t               disp [PORT_NUM];
    logic [PORT_NUM-1:0] can_disp;
    logic [PORT_NUM-1:0] issue_req;
    logic [PORT_NUM-1:0] can_issue;
    issue_t              issue [PORT_NUM];
    logic [WB_NUM-1:0]   wb_vld;
    preg_t               wb_tag [WB_NUM];

    event_t      events [$];
    logic [2:0]  modes [$];
    logic [63:0] expects [$];
    int          n_cases;
    int          n_checks;
    int          n_errors;
    int          case_errors;
    bit          parsed;

    // reference model of pending registers and per-rob state
    logic [63:0] pending;
    logic [63:0] waiting;
    logic [63:0] rdy0;
    logic [63:0] rdy1;
    logic [63:0] issued;
    disp_t       info [64];

    issue_unit dut0 (
        .clk         (clk),
        .i_arst_n    (arst_n),
        .i_disp_vld  (disp_vld),
        .i_disp      (disp),
        .o_can_disp  (can_disp),
        .i_issue_req (issue_req),
        .o_can_issue (can_issue),
        .o_issue     (issue),
        .i_wb_vld    (wb_vld),
        .i_wb_tag    (wb_tag)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic compare_values(input logic [63:0] got, input logic [63:0] exp,
                                  input string msg);
        n_checks++;
        if (got !== exp) begin
            $display("FAIL %0d ns: %s, got %0h, expected %0h", $time, msg, got, exp);
            n_errors++;
            case_errors++;
        end
    endtask

    function automatic logic wb_hit(input preg_t tag);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < WB_NUM; w++) begin
            if (wb_vld[w] && wb_tag[w] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic issue_t issue_from_disp(input disp_t d);
        issue_t r;
        r.op     = d.op;
        r.src0   = d.src0;
        r.src1   = d.src1;
        r.rd     = d.rd;
        r.rd_wen = d.rd_wen;
        r.rob    = d.rob;
        return r;
    endfunction

    task automatic reset_dut();
        @(posedge clk);
        #1;
        arst_n = 1'b0;
        disp_vld = '0;
        wb_vld = '0;
        issue_req = '0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        pending = '0;
        waiting = '0;
        rdy0 = '0;
        rdy1 = '0;
        issued = '0;
        compare_values(can_issue, '0, "can_issue after reset");
        compare_values(can_disp, {PORT_NUM{1'b1}}, "can_disp after reset");
    endtask

    task automatic drive_cycle(input int k, input int c, inout logic [2:0] mode);
        logic [31:0] rand_word;
        disp_vld = '0;
        wb_vld = '0;
        foreach (events[i]) begin
            if (events[i].cidx == k && events[i].cyc == c) begin
                case (events[i].kind)
                    "d": begin
                        disp_vld[events[i].port] = 1'b1;
                        disp[events[i].port] = events[i].d;
                    end
                    "w": begin
                        wb_vld[events[i].port] = 1'b1;
                        wb_tag[events[i].port] = events[i].a[PREG_W-1:0];
                    end
                    "r": mode = events[i].a[2:0];
                    default: ;
                endcase
            end
        end
        rand_word = $urandom;
        issue_req = (mode == 3'd4) ? rand_word[PORT_NUM-1:0] : mode[PORT_NUM-1:0];
    endtask

    task automatic check_cycle(input int k, input int c);
        logic [5:0]  rob;
        logic [63:0] clr;
        logic [63:0] set;
        foreach (events[i]) begin
            if (events[i].cidx == k && events[i].cyc == c && events[i].kind == "k") begin
                compare_values(can_disp, events[i].a, "can_disp");
                compare_values(can_issue, events[i].b, "can_issue");
            end
        end
        // offers come from state before this cycle's writebacks
        for (int p = 0; p < PORT_NUM; p++) begin
            if (can_issue[p]) begin
                rob = issue[p].rob;
                compare_values(waiting[rob] && rdy0[rob] && rdy1[rob], 1,
                               "offered rob is issuable");
                compare_values(issue[p], issue_from_disp(info[rob]), "issue payload");
                if (issue_req[p]) begin
                    compare_values(issued[rob], 0, "rob issued only once");
                    issued[rob] = 1'b1;
                    waiting[rob] = 1'b0;
                end
            end
        end
        clr = '0;
        set = '0;
        for (int w = 0; w < WB_NUM; w++) begin
            if (wb_vld[w]) begin
                clr[wb_tag[w]] = 1'b1;
                for (int r = 0; r < 64; r++) begin
                    if (waiting[r] && info[r].src0 == wb_tag[w]) begin
                        rdy0[r] = 1'b1;
                    end
                    if (waiting[r] && info[r].src1 == wb_tag[w]) begin
                        rdy1[r] = 1'b1;
                    end
                end
            end
        end
        for (int p = 0; p < PORT_NUM; p++) begin
            if (disp_vld[p]) begin
                compare_values(can_disp[p], 1, "dispatch accepted");
                rob = disp[p].rob;
                waiting[rob] = 1'b1;
                info[rob] = disp[p];
                rdy0[rob] = !pending[disp[p].src0] || wb_hit(disp[p].src0);
                rdy1[rob] = !pending[disp[p].src1] || wb_hit(disp[p].src1);
                if (disp[p].rd_wen) begin
                    set[disp[p].rd] = 1'b1;
                end
            end
        end
        // new producer wins over a writeback of the same tag
        pending = (pending & ~clr) | set;
    endtask

    initial begin
        wait (parsed);
        #((n_cases + 1) * CASE_CYCLES * 10);
        $display("timeout: issue stage stopped issuing");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int          fd;
        int          r;
        int          c;
        int          last;
        int          tail;
        int          seed;
        int          v [8];
        byte         kind;
        logic [2:0]  mode;
        logic [63:0] mask;
        logic [8*200-1:0] skip;
        event_t      ev;

        arst_n = 1'b0;
        disp_vld = '0;
        issue_req = '0;
        wb_vld = '0;
        for (int p = 0; p < PORT_NUM; p++) begin
            disp[p] = '0;
        end
        for (int w = 0; w < WB_NUM; w++) begin
            wb_tag[w] = '0;
        end
        seed = 99751;
        r = $urandom(seed);

        fd = $fopen("bench/issue_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file bench/issue_cases.txt");
            n_errors++;
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                ev = '0;
                ev.kind = kind;
                ev.cidx = 8'(n_cases - 1);
                case (kind)
                    "#": r = $fgets(skip, fd);
                    "c": begin
                        r = $fscanf(fd, "%h", v[0]);
                        modes.push_back(v[0][2:0]);
                        n_cases++;
                    end
                    "e": begin
                        r = $fscanf(fd, "%h", mask);
                        expects.push_back(mask);
                    end
                    "d": begin
                        r = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                        ev.cyc = 16'(v[0]);
                        ev.port = 2'(v[1]);
                        ev.d.op = 8'(v[2]);
                        ev.d.src0 = preg_t'(v[3]);
                        ev.d.src1 = preg_t'(v[4]);
                        ev.d.rd = preg_t'(v[5]);
                        ev.d.rd_wen = v[6][0];
                        ev.d.rob = rob_t'(v[7]);
                        events.push_back(ev);
                    end
                    "w", "k": begin
                        r = $fscanf(fd, "%h %h %h", v[0], v[1], v[2]);
                        ev.cyc = 16'(v[0]);
                        ev.port = (kind == "w") ? 2'(v[1]) : 2'd0;
                        ev.a = (kind == "w") ? 8'(v[2]) : 8'(v[1]);
                        ev.b = 8'(v[2]);
                        events.push_back(ev);
                    end
                    "r": begin
                        r = $fscanf(fd, "%h %h", v[0], v[1]);
                        ev.cyc = 16'(v[0]);
                        ev.a = 8'(v[1]);
                        events.push_back(ev);
                    end
                    default: begin
                        $display("unexpected line kind %c in the case file", kind);
                        n_errors++;
                    end
                endcase
            end
            $fclose(fd);
        end
        if (expects.size() != n_cases) begin
            $display("case file does not close every case with an end line");
            n_errors++;
        end
        parsed = 1'b1;

        for (int k = 0; k < n_cases; k++) begin
            case_errors = 0;
            reset_dut();
            mode = modes[k];
            last = 0;
            foreach (events[i]) begin
                if (events[i].cidx == k && events[i].cyc > last) begin
                    last = events[i].cyc;
                end
            end
            c = 0;
            tail = 4;
            // a few idle cycles after the last expected issue catch repeats
            while (tail > 0) begin
                drive_cycle(k, c, mode);
                @(negedge clk);
                check_cycle(k, c);
                @(posedge clk);
                #1;
                if (c >= last && $countones(issued) >= $countones(expects[k])) begin
                    tail--;
                end
                c++;
            end
            compare_values(issued, expects[k], "issued rob set");
            $display("case %0d: %0d cycles, %0d errors", k, c, case_errors);
        end

        $display("%0d cases, %0d checks, %0d errors", n_cases, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* design/busy_table.sv */
`timescale 1ns/1ps

module busy_table import issue_pkg::*; #(
    parameter int PORT_NUM = 2,
    parameter int WB_NUM = 4
) (
    input  logic                  clk,
    input  logic                  i_arst_n,

    // destinations of accepted dispatches
    input  logic [PORT_NUM-1:0]   i_set_vld,
    input  preg_t                 i_set_tag [PORT_NUM],

    // writeback clears
    input  logic [WB_NUM-1:0]     i_wb_vld,
    input  preg_t                 i_wb_tag [WB_NUM],

    // two source lookups per dispatch port, src0 at 2*p, src1 at 2*p+1
    input  preg_t                 i_look_tag [2*PORT_NUM],
    output logic [2*PORT_NUM-1:0] o_look_rdy
);

    logic [PREG_NUM-1:0] pending;
    logic [PREG_NUM-1:0] set_mask;
    logic [PREG_NUM-1:0] clr_mask;
    logic [31:0]         wb_vld_ext;
    preg_t               wb_tag_ext [32];

    always_comb begin
        wb_vld_ext = '0;
        for (int w = 0; w < 32; w++) begin
            wb_tag_ext[w] = '0;
        end
        for (int w = 0; w < WB_NUM; w++) begin
            wb_vld_ext[w] = i_wb_vld[w];
            wb_tag_ext[w] = i_wb_tag[w];
        end
    end

    // lookup, writeback in the same cycle counts as ready
    always_comb begin
        for (int l = 0; l < 2*PORT_NUM; l++) begin
            o_look_rdy[l] = !pending[i_look_tag[l]]
                || tag_hit(i_look_tag[l], wb_vld_ext, wb_tag_ext, WB_NUM);
        end
    end

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        for (int p = 0; p < PORT_NUM; p++) begin
            if (i_set_vld[p]) begin
                set_mask[i_set_tag[p]] = 1'b1;
            end
        end
        for (int w = 0; w < WB_NUM; w++) begin
            if (i_wb_vld[w]) begin
                clr_mask[i_wb_tag[w]] = 1'b1;
            end
        end
    end

    // a new producer beats an old writeback on the same tag
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clr_mask) | set_mask;
        end
    end

endmodule

/* design/issue_pkg.sv */
package issue_pkg;

    // physical register tag width, 64 registers
    localparam int PREG_W = 6;
    localparam int PREG_NUM = 1 << PREG_W;

    localparam int ROB_W = 6;
    localparam int OP_W = 8;

    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [ROB_W-1:0] rob_t;
    typedef logic [OP_W-1:0] op_t;

    // one instruction as it leaves rename
    typedef struct packed {
        op_t   op;
        preg_t src0;
        preg_t src1;
        preg_t rd;
        logic  rd_wen;
        rob_t  rob;
    } disp_t;

    // station slot, instruction plus operand ready bits
    typedef struct packed {
        disp_t info;
        logic  src0_rdy;
        logic  src1_rdy;
    } entry_t;

    // handed to the register read stage
    typedef struct packed {
        op_t   op;
        preg_t src0;
        preg_t src1;
        preg_t rd;
        logic  rd_wen;
        rob_t  rob;
    } issue_t;

    // strip the ready bits off a stored entry
    function automatic issue_t entry_to_issue(input entry_t e);
        issue_t r;
        r.op     = e.info.op;
        r.src0   = e.info.src0;
        r.src1   = e.info.src1;
        r.rd     = e.info.rd;
        r.rd_wen = e.info.rd_wen;
        r.rob    = e.info.rob;
        return r;
    endfunction

    // true when any valid writeback carries this tag
    function automatic logic tag_hit(
        input preg_t       tag,
        input logic [31:0] wb_vld,
        input preg_t       wb_tag [32],
        input int          wb_num
    );
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < wb_num; w++) begin
            if (wb_vld[w] && (wb_tag[w] == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

endpackage

/* design/issue_unit.sv */
`timescale 1ns/1ps

module issue_unit import issue_pkg::*; #(
    parameter int DEPTH = 8,
    parameter int PORT_NUM = 2,
    parameter int WB_NUM = 4
) (
    input  logic                clk,
    input  logic                i_arst_n,

    // dispatch from rename
    input  logic [PORT_NUM-1:0] i_disp_vld,
    input  disp_t               i_disp [PORT_NUM],
    output logic [PORT_NUM-1:0] o_can_disp,

    // issue toward register read
    input  logic [PORT_NUM-1:0] i_issue_req,
    output logic [PORT_NUM-1:0] o_can_issue,
    output issue_t              o_issue [PORT_NUM],

    // writeback broadcast
    input  logic [WB_NUM-1:0]   i_wb_vld,
    input  preg_t               i_wb_tag [WB_NUM]
);

    preg_t                 look_tag [2*PORT_NUM];
    logic [2*PORT_NUM-1:0] look_rdy;
    logic [PORT_NUM-1:0]   set_vld;
    preg_t                 set_tag [PORT_NUM];
    entry_t                enq [PORT_NUM];

    for (genvar p = 0; p < PORT_NUM; p++) begin : g_port
        assign look_tag[2*p]   = i_disp[p].src0;
        assign look_tag[2*p+1] = i_disp[p].src1;

        // only taken dispatches mark their destination busy
        assign set_vld[p] = i_disp_vld[p] & o_can_disp[p] & i_disp[p].rd_wen;
        assign set_tag[p] = i_disp[p].rd;

        assign enq[p].info     = i_disp[p];
        assign enq[p].src0_rdy = look_rdy[2*p];
        assign enq[p].src1_rdy = look_rdy[2*p+1];
    end

    busy_table #(
        .PORT_NUM (PORT_NUM),
        .WB_NUM   (WB_NUM)
    ) u_busy (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_set_vld  (set_vld),
        .i_set_tag  (set_tag),
        .i_wb_vld   (i_wb_vld),
        .i_wb_tag   (i_wb_tag),
        .i_look_tag (look_tag),
        .o_look_rdy (look_rdy)
    );

    reservation_station #(
        .DEPTH    (DEPTH),
        .PORT_NUM (PORT_NUM),
        .WB_NUM   (WB_NUM)
    ) u_rs (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_enq_vld (i_disp_vld),
        .i_enq     (enq),
        .o_can_enq (o_can_disp),
        .i_deq_req (i_issue_req),
        .o_can_deq (o_can_issue),
        .o_deq     (o_issue),
        .i_wb_vld  (i_wb_vld),
        .i_wb_tag  (i_wb_tag)
    );

endmodule

/* design/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station import issue_pkg::*; #(
    parameter int DEPTH = 8,
    parameter int PORT_NUM = 2,
    parameter int WB_NUM = 4
) (
    input  logic                clk,
    input  logic                i_arst_n,

    // enqueue side
    input  logic [PORT_NUM-1:0] i_enq_vld,
    input  entry_t              i_enq [PORT_NUM],
    output logic [PORT_NUM-1:0] o_can_enq,

    // issue side, registered offer
    input  logic [PORT_NUM-1:0] i_deq_req,
    output logic [PORT_NUM-1:0] o_can_deq,
    output issue_t              o_deq [PORT_NUM],

    // writeback tags for wakeup
    input  logic [WB_NUM-1:0]   i_wb_vld,
    input  preg_t               i_wb_tag [WB_NUM]
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    entry_t              buffer [DEPTH];
    logic [DEPTH-1:0]    vld;
    logic [CNT_W-1:0]    count;

    logic [PORT_NUM-1:0] enq_take;
    logic [PORT_NUM-1:0] deq_take;
    logic [CNT_W-1:0]    enq_num;
    logic [CNT_W-1:0]    deq_num;

    logic [DEPTH-1:0]    src0_wake;
    logic [DEPTH-1:0]    src1_wake;
    logic [DEPTH-1:0]    deq_mask;
    logic [DEPTH-1:0]    ready;

    logic [IDX_W-1:0]    enq_idx [PORT_NUM];
    logic [IDX_W-1:0]    deq_idx [PORT_NUM];
    logic [PORT_NUM-1:0] deq_found;

    logic [PORT_NUM-1:0] saved_found;
    logic [IDX_W-1:0]    saved_idx [PORT_NUM];

    // free slot count gates each dispatch port
    for (genvar p = 0; p < PORT_NUM; p++) begin : g_can_enq
        assign o_can_enq[p] = (DEPTH - int'(count)) > p;
    end

    assign enq_take  = i_enq_vld & o_can_enq;
    assign deq_take  = i_deq_req & saved_found;
    assign o_can_deq = saved_found;

    always_comb begin
        enq_num = '0;
        deq_num = '0;
        for (int p = 0; p < PORT_NUM; p++) begin
            enq_num = enq_num + CNT_W'(enq_take[p]);
            deq_num = deq_num + CNT_W'(deq_take[p]);
        end
    end

    // entries leaving this cycle must not be picked again
    always_comb begin
        deq_mask = '0;
        for (int p = 0; p < PORT_NUM; p++) begin
            if (deq_take[p]) begin
                deq_mask[saved_idx[p]] = 1'b1;
            end
        end
        for (int e = 0; e < DEPTH; e++) begin
            ready[e] = vld[e] && buffer[e].src0_rdy && buffer[e].src1_rdy;
        end
        ready = ready & ~deq_mask;
    end

    rs_wakeup #(
        .DEPTH  (DEPTH),
        .WB_NUM (WB_NUM)
    ) u_wakeup (
        .i_entry     (buffer),
        .i_wb_vld    (i_wb_vld),
        .i_wb_tag    (i_wb_tag),
        .o_src0_wake (src0_wake),
        .o_src1_wake (src1_wake)
    );

    rs_select #(
        .DEPTH    (DEPTH),
        .PORT_NUM (PORT_NUM)
    ) u_select (
        .i_free      (~vld),
        .i_ready     (ready),
        .o_enq_idx   (enq_idx),
        .o_deq_idx   (deq_idx),
        .o_deq_found (deq_found)
    );

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            vld         <= '0;
            count       <= '0;
            saved_found <= '0;
        end else begin
            count       <= count + enq_num - deq_num;
            saved_found <= deq_found;
            for (int p = 0; p < PORT_NUM; p++) begin
                if (deq_take[p]) begin
                    vld[saved_idx[p]] <= 1'b0;
                end
                // enqueue only lands on a free slot, never one being freed
                if (enq_take[p]) begin
                    vld[enq_idx[p]] <= 1'b1;
                end
            end
        end
    end

    // payload and selected indices, qualified by vld and saved_found
    always_ff @(posedge clk) begin
        saved_idx <= deq_idx;
        for (int e = 0; e < DEPTH; e++) begin
            if (src0_wake[e]) begin
                buffer[e].src0_rdy <= 1'b1;
            end
            if (src1_wake[e]) begin
                buffer[e].src1_rdy <= 1'b1;
            end
        end
        // new entries already carry forwarded ready bits
        for (int p = 0; p < PORT_NUM; p++) begin
            if (enq_take[p]) begin
                buffer[enq_idx[p]] <= i_enq[p];
            end
        end
    end

    for (genvar p = 0; p < PORT_NUM; p++) begin : g_deq
        assign o_deq[p] = entry_to_issue(buffer[saved_idx[p]]);
    end

endmodule

/* design/rs_select.sv */
`timescale 1ns/1ps

module rs_select #(
    parameter int DEPTH = 8,
    parameter int PORT_NUM = 2
) (
    input  logic [DEPTH-1:0]         i_free,
    input  logic [DEPTH-1:0]         i_ready,
    output logic [$clog2(DEPTH)-1:0] o_enq_idx [PORT_NUM],
    output logic [$clog2(DEPTH)-1:0] o_deq_idx [PORT_NUM],
    output logic [PORT_NUM-1:0]      o_deq_found
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [DEPTH-1:0] free_left;
    logic [DEPTH-1:0] ready_left;

    // index of the lowest set bit, zero when the mask is empty
    function automatic logic [IDX_W-1:0] first_set(input logic [DEPTH-1:0] mask);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int k = DEPTH-1; k >= 0; k--) begin
            if (mask[k]) begin
                idx = IDX_W'(k);
            end
        end
        return idx;
    endfunction

    // port p picks from what ports below it left over
    always_comb begin
        free_left  = i_free;
        ready_left = i_ready;
        for (int p = 0; p < PORT_NUM; p++) begin
            o_enq_idx[p] = first_set(free_left);
            o_deq_idx[p] = first_set(ready_left);
            o_deq_found[p] = |ready_left;

            // clearing an already empty bit 0 is harmless
            free_left[o_enq_idx[p]]  = 1'b0;
            ready_left[o_deq_idx[p]] = 1'b0;
        end
    end

endmodule

/* design/rs_wakeup.sv */
`timescale 1ns/1ps

module rs_wakeup import issue_pkg::*; #(
    parameter int DEPTH = 8,
    parameter int WB_NUM = 4
) (
    input  entry_t             i_entry [DEPTH],
    input  logic [WB_NUM-1:0]  i_wb_vld,
    input  preg_t              i_wb_tag [WB_NUM],
    output logic [DEPTH-1:0]   o_src0_wake,
    output logic [DEPTH-1:0]   o_src1_wake
);

    logic [31:0] wb_vld_ext;
    preg_t       wb_tag_ext [32];

    // widen to the fixed shape the compare helper takes
    always_comb begin
        wb_vld_ext = '0;
        for (int w = 0; w < 32; w++) begin
            wb_tag_ext[w] = '0;
        end
        for (int w = 0; w < WB_NUM; w++) begin
            wb_vld_ext[w] = i_wb_vld[w];
            wb_tag_ext[w] = i_wb_tag[w];
        end
    end

    // full crossbar of entry sources against writeback tags
    always_comb begin
        for (int e = 0; e < DEPTH; e++) begin
            o_src0_wake[e] = tag_hit(
                i_entry[e].info.src0, wb_vld_ext, wb_tag_ext, WB_NUM
            );
            o_src1_wake[e] = tag_hit(
                i_entry[e].info.src1, wb_vld_ext, wb_tag_ext, WB_NUM
            );
        end
    end

endmodule

/* issue_unit.f */
design/issue_pkg.sv
design/busy_table.sv
design/rs_wakeup.sv
design/rs_select.sv
design/reservation_station.sv
design/issue_unit.sv
bench/tb_issue_unit.sv
